// File: verilog/vpack_pkg.sv
//////////////////////////////////////////////////
// Shared widths, element-width codes and vector
// types for the vector write-back slice
//////////////////////////////////////////////////

package vpack_pkg;

    localparam int unsigned VREG_CNT = 32;  // vector registers
    localparam int unsigned VADDR_W  = 5;
    localparam int unsigned ID_W     = 3;
    localparam int unsigned ELEM_MAX = 16;  // elements per register at 8 bits

    typedef logic [VADDR_W-1:0]  vaddr_t;
    typedef logic [ID_W-1:0]     instr_id_t;
    typedef logic [1:0]          eew_t;
    typedef logic [VREG_CNT-1:0] vreg_mask_t;  // one bit per register
    typedef logic [ELEM_MAX-1:0] elem_mask_t;  // one bit per element

    // element width codes, 3 is reserved
    localparam eew_t EEW_8  = 2'd0;
    localparam eew_t EEW_16 = 2'd1;
    localparam eew_t EEW_32 = 2'd2;

    typedef enum logic {
        IDLE,
        EMIT
    } gen_state_e;

endpackage

// File: verilog/vpack_result_if.sv
//////////////////////////////////////////////////
// Element result beats from the generator to the
// packer, valid/ready handshake
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface vpack_result_if #(
    parameter int unsigned RES_W = 32
);

    logic                 valid;
    logic                 ready;
    vpack_pkg::instr_id_t instr_id;
    vpack_pkg::eew_t      eew;
    vpack_pkg::vaddr_t    vaddr;
    logic [RES_W-1:0]     data;   // element in low bits
    logic [RES_W/8-1:0]   be;
    logic                 store;  // last beat, write the word
    logic                 done;   // instruction finished

    modport gen (
        output valid, instr_id, eew, vaddr, data, be, store, done,
        input  ready
    );

    modport pack (
        input  valid, instr_id, eew, vaddr, data, be, store, done,
        output ready
    );

endinterface

// File: verilog/vpack_wr_if.sv
//////////////////////////////////////////////////
// Register file write port, packer to register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface vpack_wr_if #(
    parameter int unsigned VPORT_W = 128
);

    logic                 valid;
    logic                 ready;
    vpack_pkg::vaddr_t    addr;
    logic [VPORT_W/8-1:0] be;    // byte enables
    logic [VPORT_W-1:0]   data;

    modport src (
        output valid, addr, be, data,
        input  ready
    );

    modport dst (
        input  valid, addr, be, data,
        output ready
    );

endinterface

// File: verilog/vpack_elem_gen.sv
//////////////////////////////////////////////////
// Element generator: expands a command into one
// result beat per element, base + i * step, and
// keeps the pending-write scoreboard
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_elem_gen #(
    parameter int unsigned VPORT_W = 128,
    parameter int unsigned RES_W   = 32
) (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  vpack_pkg::instr_id_t  cmd_id_i,
    input  vpack_pkg::eew_t       cmd_eew_i,
    input  vpack_pkg::vaddr_t     cmd_vaddr_i,
    input  logic [RES_W-1:0]      cmd_base_i,
    input  logic [RES_W-1:0]      cmd_step_i,
    input  vpack_pkg::elem_mask_t cmd_mask_i,
    input  vpack_pkg::vreg_mask_t clear_pending_i,
    output vpack_pkg::vreg_mask_t pend_writes_o,
    vpack_result_if.gen           res
);

    localparam int unsigned CNT_W = $clog2(VPORT_W / 8);

    vpack_pkg::gen_state_e state_q;
    vpack_pkg::vreg_mask_t pend_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [CNT_W-1:0]      last_idx;
    vpack_pkg::instr_id_t  id_q;
    vpack_pkg::eew_t       eew_q;
    vpack_pkg::vaddr_t     vaddr_q;
    vpack_pkg::elem_mask_t mask_q;
    logic [RES_W-1:0]      step_q;
    logic [RES_W-1:0]      value_q;  // running element value
    logic                  cmd_fire;
    logic                  beat_fire;
    logic                  last_beat;
    logic                  mask_bit;

    // refuse a destination that still has a write in flight
    assign cmd_ready_o = (state_q == vpack_pkg::IDLE) & ~pend_q[cmd_vaddr_i];
    assign cmd_fire    = cmd_valid_i & cmd_ready_o;
    assign beat_fire   = res.valid & res.ready;

    always_comb begin
        case (eew_q)
            vpack_pkg::EEW_8:  last_idx = CNT_W'(VPORT_W / 8 - 1);
            vpack_pkg::EEW_16: last_idx = CNT_W'(VPORT_W / 16 - 1);
            default:           last_idx = CNT_W'(VPORT_W / 32 - 1);
        endcase
    end

    assign last_beat = (cnt_q == last_idx);
    assign mask_bit  = mask_q[cnt_q];

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= vpack_pkg::IDLE;
            cnt_q   <= '0;
            pend_q  <= '0;
        end else begin
            pend_q <= pend_q & ~clear_pending_i;
            if (cmd_fire) begin
                state_q             <= vpack_pkg::EMIT;
                cnt_q               <= '0;
                pend_q[cmd_vaddr_i] <= 1'b1;  // never clearing in the same cycle
            end else if (beat_fire) begin
                cnt_q <= cnt_q + 1'b1;
                if (last_beat) begin
                    state_q <= vpack_pkg::IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            id_q    <= cmd_id_i;
            eew_q   <= cmd_eew_i;
            vaddr_q <= cmd_vaddr_i;
            mask_q  <= cmd_mask_i;
            step_q  <= cmd_step_i;
            value_q <= cmd_base_i;
        end else if (beat_fire) begin
            value_q <= value_q + step_q;
        end
    end

    assign res.valid    = (state_q == vpack_pkg::EMIT);
    assign res.instr_id = id_q;
    assign res.eew      = eew_q;
    assign res.vaddr    = vaddr_q;
    assign res.store    = last_beat;
    assign res.done     = last_beat;  // one write per command

    // cut the value to the element width, enable its bytes only
    always_comb begin
        case (eew_q)
            vpack_pkg::EEW_8: begin
                res.data = {{(RES_W - 8){1'b0}}, value_q[7:0]};
                res.be   = {{(RES_W / 8 - 1){1'b0}}, mask_bit};
            end
            vpack_pkg::EEW_16: begin
                res.data = {{(RES_W - 16){1'b0}}, value_q[15:0]};
                res.be   = {{(RES_W / 8 - 2){1'b0}}, {2{mask_bit}}};
            end
            default: begin
                res.data = value_q;
                res.be   = {(RES_W / 8){mask_bit}};
            end
        endcase
    end

    assign pend_writes_o = pend_q;

endmodule

// File: verilog/vpack_packer.sv
//////////////////////////////////////////////////
// Packer: shifts element beats into a register-wide
// word and writes it on the last beat, then clears
// the destination's pending-write bit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_packer #(
    parameter int unsigned VPORT_W = 128,
    parameter int unsigned RES_W   = 32
) (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  vpack_pkg::vreg_mask_t pend_reads_i,
    output vpack_pkg::vreg_mask_t clear_pending_o,
    output logic                  done_valid_o,
    output vpack_pkg::instr_id_t  done_id_o,
    vpack_result_if.pack          res,
    vpack_wr_if.src               wr
);

    localparam int unsigned BE_W = VPORT_W / 8;

    // stage register
    logic                 stage_valid_q;
    vpack_pkg::instr_id_t id_q;
    vpack_pkg::vaddr_t    vaddr_q;
    logic                 store_q;
    logic                 done_q;
    logic [VPORT_W-1:0]   data_q;
    logic [BE_W-1:0]      be_q;

    logic [VPORT_W-1:0]   data_next;
    logic [BE_W-1:0]      be_next;
    logic                 stage_stall;
    logic                 stage_ready;
    logic                 wr_fire;
    vpack_pkg::vreg_mask_t clear_d;
    vpack_pkg::vreg_mask_t clear_q;

    // shift right by one element, new element enters at the top
    always_comb begin
        int unsigned elem_w;
        case (res.eew)
            vpack_pkg::EEW_8:  elem_w = 8;
            vpack_pkg::EEW_16: elem_w = 16;
            default:           elem_w = RES_W;  // widest element fills the result
        endcase
        data_next = (data_q >> elem_w) | (VPORT_W'(res.data) << (VPORT_W - elem_w));
        be_next   = (be_q >> (elem_w / 8)) | (BE_W'(res.be) << (BE_W - elem_w / 8));
    end

    // hold a finished word while its destination is still being read
    assign stage_stall = stage_valid_q & store_q & pend_reads_i[vaddr_q];
    assign stage_ready = ~stage_valid_q | ((~store_q | wr.ready) & ~stage_stall);
    assign res.ready   = stage_ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage_valid_q <= 1'b0;
            clear_q       <= '0;
        end else begin
            if (stage_ready) begin
                stage_valid_q <= res.valid;
            end
            clear_q <= clear_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready && res.valid) begin
            id_q    <= res.instr_id;
            vaddr_q <= res.vaddr;
            store_q <= res.store;
            done_q  <= res.done;
            data_q  <= data_next;
            be_q    <= be_next;
        end
    end

    assign wr.valid = stage_valid_q & store_q & ~stage_stall;
    assign wr.addr  = vaddr_q;
    assign wr.be    = be_q;
    assign wr.data  = data_q;
    assign wr_fire  = wr.valid & wr.ready;

    assign done_valid_o = wr_fire & done_q;
    assign done_id_o    = id_q;

    // one-hot clear, registered so it lands the cycle after the write
    always_comb begin
        clear_d = '0;
        if (wr_fire) begin
            clear_d[vaddr_q] = 1'b1;
        end
    end

    assign clear_pending_o = clear_q;

endmodule

// File: verilog/vpack_vreg_file.sv
//////////////////////////////////////////////////
// Vector register file, 32 entries, byte-enable
// write port and a combinational read port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_vreg_file #(
    parameter int unsigned VPORT_W = 128
) (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               vrf_stall_i,
    input  vpack_pkg::vaddr_t  rd_addr_i,
    output logic [VPORT_W-1:0] rd_data_o,
    vpack_wr_if.dst            wr
);

    localparam int unsigned BE_W = VPORT_W / 8;

    logic [VPORT_W-1:0] regs_q [vpack_pkg::VREG_CNT];
    logic               wr_fire;

    assign wr.ready = ~vrf_stall_i;  // throttled from outside
    assign wr_fire  = wr.valid & wr.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            for (int r = 0; r < vpack_pkg::VREG_CNT; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_fire) begin
            // untouched bytes keep their value
            for (int b = 0; b < BE_W; b++) begin
                if (wr.be[b]) begin
                    regs_q[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // observation read, sees a write from the next cycle on
    assign rd_data_o = regs_q[rd_addr_i];

endmodule

// File: verilog/vpack_top.sv
//////////////////////////////////////////////////
// Write-back slice top level: generator, packer
// and register file behind plain ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_top #(
    parameter int unsigned VPORT_W = 128,
    parameter int unsigned RES_W   = 32
) (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    // command
    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  vpack_pkg::instr_id_t  cmd_id_i,
    input  vpack_pkg::eew_t       cmd_eew_i,
    input  vpack_pkg::vaddr_t     cmd_vaddr_i,
    input  logic [RES_W-1:0]      cmd_base_i,
    input  logic [RES_W-1:0]      cmd_step_i,
    input  vpack_pkg::elem_mask_t cmd_mask_i,

    input  vpack_pkg::vreg_mask_t pend_reads_i,  // registers being read
    input  logic                  vrf_stall_i,

    input  vpack_pkg::vaddr_t     rd_addr_i,
    output logic [VPORT_W-1:0]    rd_data_o,

    output vpack_pkg::vreg_mask_t pend_writes_o,
    output logic                  done_valid_o,
    output vpack_pkg::instr_id_t  done_id_o
);

    vpack_result_if #(.RES_W(RES_W)) res_if ();
    vpack_wr_if #(.VPORT_W(VPORT_W)) wr_if ();

    vpack_pkg::vreg_mask_t clear_pending;

    vpack_elem_gen #(
        .VPORT_W (VPORT_W),
        .RES_W   (RES_W)
    ) i_elem_gen (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_ready_o     (cmd_ready_o),
        .cmd_id_i        (cmd_id_i),
        .cmd_eew_i       (cmd_eew_i),
        .cmd_vaddr_i     (cmd_vaddr_i),
        .cmd_base_i      (cmd_base_i),
        .cmd_step_i      (cmd_step_i),
        .cmd_mask_i      (cmd_mask_i),
        .clear_pending_i (clear_pending),
        .pend_writes_o   (pend_writes_o),
        .res             (res_if.gen)
    );

    vpack_packer #(
        .VPORT_W (VPORT_W),
        .RES_W   (RES_W)
    ) i_packer (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .pend_reads_i    (pend_reads_i),
        .clear_pending_o (clear_pending),
        .done_valid_o    (done_valid_o),
        .done_id_o       (done_id_o),
        .res             (res_if.pack),
        .wr              (wr_if.src)
    );

    vpack_vreg_file #(
        .VPORT_W (VPORT_W)
    ) i_vreg_file (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .vrf_stall_i  (vrf_stall_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .wr           (wr_if.dst)
    );

endmodule

// File: verification/vpack_props.sv
//////////////////////////////////////////////////
// Concurrent checks on the packer write port,
// done flag and pending clear; bound to the packer
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_props #(
    parameter int unsigned VPORT_W = 128
) (
    input logic                  clk_i,
    input logic                  async_rst_ni,
    input logic                  wr_valid_i,
    input logic                  wr_ready_i,
    input vpack_pkg::vaddr_t     wr_addr_i,
    input logic [VPORT_W/8-1:0]  wr_be_i,
    input logic [VPORT_W-1:0]    wr_data_i,
    input logic                  done_valid_i,
    input vpack_pkg::vreg_mask_t clear_pending_i
);

    // offered word holds until the register file takes it
    wr_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_i && !wr_ready_i |=>
            wr_valid_i && $stable(wr_addr_i) && $stable(wr_be_i) && $stable(wr_data_i))
        else $error("write port changed while the register file stalled");

    // done marks every write transfer and nothing else
    done_on_write: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        done_valid_i == (wr_valid_i && wr_ready_i))
        else $error("done flag does not match the write transfer");

    // only the written register's bit is cleared
    clear_after_write: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_i && wr_ready_i |=>
            clear_pending_i == (vpack_pkg::vreg_mask_t'(1) << $past(wr_addr_i)))
        else $error("pending clear does not match the written register");

endmodule

bind vpack_packer vpack_props #(.VPORT_W(VPORT_W)) i_vpack_props (
    .clk_i           (clk_i),
    .async_rst_ni    (async_rst_ni),
    .wr_valid_i      (wr.valid),
    .wr_ready_i      (wr.ready),
    .wr_addr_i       (wr.addr),
    .wr_be_i         (wr.be),
    .wr_data_i       (wr.data),
    .done_valid_i    (done_valid_o),
    .clear_pending_i (clear_pending_o)
);

// File: verification/vpack_tb.sv
//////////////////////////////////////////////////
// Testbench for the write-back slice: drives
// commands, keeps a shadow register file and
// checks writes, done order and pending bits
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vpack_tb;

    localparam int unsigned VPORT_W = 128;
    localparam int unsigned RES_W   = 32;
    localparam int          CMD_CNT = 40;
    localparam int          TIMEOUT = CMD_CNT * 100;  // 16 beats plus stall slack per command

    logic                  clk_i;
    logic                  async_rst_ni;
    logic                  cmd_valid_i;
    logic                  cmd_ready_o;
    vpack_pkg::instr_id_t  cmd_id_i;
    vpack_pkg::eew_t       cmd_eew_i;
    vpack_pkg::vaddr_t     cmd_vaddr_i;
    logic [RES_W-1:0]      cmd_base_i;
    logic [RES_W-1:0]      cmd_step_i;
    vpack_pkg::elem_mask_t cmd_mask_i;
    vpack_pkg::vreg_mask_t pend_reads_i;
    logic                  vrf_stall_i;
    vpack_pkg::vaddr_t     rd_addr_i;
    logic [VPORT_W-1:0]    rd_data_o;
    vpack_pkg::vreg_mask_t pend_writes_o;
    logic                  done_valid_o;
    vpack_pkg::instr_id_t  done_id_o;

    // command record per ID, shadow copy of the register file
    vpack_pkg::eew_t       c_eew [8];
    vpack_pkg::vaddr_t     c_vaddr [8];
    logic [RES_W-1:0]      c_base [8];
    logic [RES_W-1:0]      c_step [8];
    vpack_pkg::elem_mask_t c_mask [8];
    logic [VPORT_W-1:0]    shadow [vpack_pkg::VREG_CNT];
    vpack_pkg::instr_id_t  exp_ids [$];  // acceptance order

    vpack_pkg::vreg_mask_t exp_pend;
    vpack_pkg::vaddr_t     acc_addr;
    vpack_pkg::vaddr_t     done_addr;
    vpack_pkg::vaddr_t     clr_addr;
    vpack_pkg::instr_id_t  next_id;
    vpack_pkg::instr_id_t  exp_id;
    logic                  acc_seen;
    logic                  done_seen;
    logic                  clr_valid;
    logic                  rand_stall;
    logic                  hold_stall;
    int                    seed;
    int                    cycles;
    int                    acc_cnt;
    int                    done_cnt;
    int                    checks;
    int                    errors;

    vpack_top #(.VPORT_W(VPORT_W), .RES_W(RES_W)) i_vpack_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // byte k of element i takes the new value only where mask bit i is set
    function automatic void apply_write(input vpack_pkg::instr_id_t id);
        int               w;
        int               n;
        logic [RES_W-1:0] v;
        w = 1 << c_eew[id];  // bytes per element
        n = VPORT_W / 8 / w;
        for (int i = 0; i < n; i++) begin
            v = c_base[id] + i * c_step[id];
            for (int k = 0; k < w; k++) begin
                if (c_mask[id][i]) begin
                    shadow[c_vaddr[id]][(i * w + k) * 8 +: 8] = v[k * 8 +: 8];
                end
            end
        end
    endfunction

    task automatic send_cmd(input vpack_pkg::eew_t eew, input vpack_pkg::vaddr_t vaddr,
                            input vpack_pkg::elem_mask_t mask);
        cmd_valid_i <= 1'b1;
        cmd_id_i    <= next_id;
        cmd_eew_i   <= eew;
        cmd_vaddr_i <= vaddr;
        cmd_base_i  <= $random(seed);
        cmd_step_i  <= $random(seed);
        cmd_mask_i  <= mask;
        @(negedge clk_i);
        while (!cmd_ready_o) @(negedge clk_i);
        @(posedge clk_i);  // accept edge
        cmd_valid_i <= 1'b0;
        next_id = next_id + 1'b1;
    endtask

    task automatic wait_idle();
        while (done_cnt != acc_cnt) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
    endtask

    task automatic check_reg(input vpack_pkg::vaddr_t r);
        rd_addr_i <= r;
        @(negedge clk_i);
        checks++;
        assert (rd_data_o == shadow[r]) else begin
            errors++;
            $display("Fail rd_data_o reg %0d expected %h actual %h", r, shadow[r], rd_data_o);
        end
        @(posedge clk_i);
    endtask

    // monitors, sampled mid-cycle
    always @(negedge clk_i) begin
        acc_seen  = 1'b0;
        done_seen = 1'b0;
        if (async_rst_ni) begin
            if (done_valid_o) begin
                checks++;
                if (exp_ids.size() == 0) begin
                    errors++;
                    $display("done_valid_o seen with no accepted command outstanding");
                end else begin
                    exp_id = exp_ids.pop_front();
                    assert (done_id_o == exp_id) else begin
                        errors++;
                        $display("Fail done_id_o expected %h actual %h", exp_id, done_id_o);
                    end
                    assert (!pend_reads_i[c_vaddr[done_id_o]]) else begin
                        errors++;
                        $display("write completed while its register had a pending read");
                    end
                    apply_write(done_id_o);
                    done_seen = 1'b1;
                    done_addr = c_vaddr[done_id_o];
                    done_cnt++;
                end
            end
            if (cmd_valid_i && cmd_ready_o) begin
                c_eew[cmd_id_i]   = cmd_eew_i;
                c_vaddr[cmd_id_i] = cmd_vaddr_i;
                c_base[cmd_id_i]  = cmd_base_i;
                c_step[cmd_id_i]  = cmd_step_i;
                c_mask[cmd_id_i]  = cmd_mask_i;
                exp_ids.push_back(cmd_id_i);
                acc_seen = 1'b1;
                acc_addr = cmd_vaddr_i;
                acc_cnt++;
            end
            assert (!(cmd_valid_i && cmd_ready_o && exp_pend[cmd_vaddr_i])) else begin
                errors++;
                $display("command accepted while its register still had a pending write");
            end
            assert (pend_writes_o == exp_pend) else begin
                errors++;
                $display("Fail pend_writes_o expected %h actual %h", exp_pend, pend_writes_o);
            end
        end
    end

    // set the cycle after accept, low two cycles after the write
    always @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            exp_pend  <= '0;
            clr_valid <= 1'b0;
        end else begin
            if (clr_valid) exp_pend[clr_addr] <= 1'b0;
            if (acc_seen) exp_pend[acc_addr] <= 1'b1;
            clr_valid <= done_seen;
            clr_addr  <= done_addr;
        end
    end

    always @(posedge clk_i) begin
        if (rand_stall) begin
            vrf_stall_i <= ($random(seed) % 2) != 0;
        end else begin
            vrf_stall_i <= hold_stall;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 32'h24d4;
        cycles     = 0;
        acc_cnt    = 0;
        done_cnt   = 0;
        checks     = 0;
        errors     = 0;
        acc_seen   = 1'b0;
        done_seen  = 1'b0;
        rand_stall = 1'b0;
        hold_stall = 1'b0;
        next_id    = '0;
        acc_addr   = '0;
        done_addr  = '0;
        for (int r = 0; r < vpack_pkg::VREG_CNT; r++) shadow[r] = '0;
        async_rst_ni = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_id_i     = '0;
        cmd_eew_i    = vpack_pkg::EEW_8;
        cmd_vaddr_i  = '0;
        cmd_base_i   = '0;
        cmd_step_i   = '0;
        cmd_mask_i   = '0;
        pend_reads_i = '0;
        vrf_stall_i  = 1'b0;
        rd_addr_i    = '0;
        repeat (4) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (cmd_ready_o && !done_valid_o) else begin
            errors++;
            $display("DUT not idle after reset");
        end
        @(posedge clk_i);

        for (int r = 1; r < 4; r++) begin  // 32-bit, full mask
            send_cmd(vpack_pkg::EEW_32, vpack_pkg::vaddr_t'(r), 16'hffff);
            wait_idle();
            check_reg(vpack_pkg::vaddr_t'(r));
        end
        for (int r = 0; r < 4; r++) begin  // 8/16 bit, two partial writes per register
            send_cmd(r[0] ? vpack_pkg::EEW_16 : vpack_pkg::EEW_8, vpack_pkg::vaddr_t'(8 + r / 2),
                     vpack_pkg::elem_mask_t'($random(seed)));
            wait_idle();
            check_reg(vpack_pkg::vaddr_t'(8 + r / 2));
        end

        // read hazard holds the write
        pend_reads_i <= 32'h0010_0000;
        send_cmd(vpack_pkg::EEW_16, 5'd20, 16'hffff);
        repeat (30) @(posedge clk_i);
        check_reg(5'd20);
        assert (done_cnt < acc_cnt) else begin
            errors++;
            $display("write finished although its register had a pending read");
        end
        pend_reads_i <= '0;
        wait_idle();
        check_reg(5'd20);

        // same register is refused while pending, another one is taken
        hold_stall <= 1'b1;
        send_cmd(vpack_pkg::EEW_32, 5'd5, 16'hffff);
        cmd_valid_i <= 1'b1;
        cmd_vaddr_i <= 5'd5;
        repeat (12) @(posedge clk_i);
        send_cmd(vpack_pkg::EEW_8, 5'd6, 16'hffff);
        hold_stall <= 1'b0;
        send_cmd(vpack_pkg::EEW_16, 5'd5, 16'h00f0);
        wait_idle();
        check_reg(5'd5);
        check_reg(5'd6);

        // random stalls and unrelated pending reads
        rand_stall <= 1'b1;
        for (int n = 0; n < 28; n++) begin
            pend_reads_i <= $random(seed) & 32'hffff_0000;
            send_cmd(vpack_pkg::eew_t'($unsigned($random(seed)) % 3),
                     vpack_pkg::vaddr_t'($unsigned($random(seed)) % 16),
                     vpack_pkg::elem_mask_t'($random(seed)));
        end
        rand_stall   <= 1'b0;
        pend_reads_i <= '0;
        wait_idle();
        for (int r = 0; r < vpack_pkg::VREG_CNT; r++) check_reg(vpack_pkg::vaddr_t'(r));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/vpack_pkg.sv
verilog/vpack_result_if.sv
verilog/vpack_wr_if.sv
verilog/vpack_elem_gen.sv
verilog/vpack_packer.sv
verilog/vpack_vreg_file.sv
verilog/vpack_top.sv
verification/vpack_props.sv
verification/vpack_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and fail when the log holds the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module vpack_tb -o vpack_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vpack_sim > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log && ! grep -q "Result: FAILED" sim.log
